/* source/rvPkg.sv */
`default_nettype none

package rvPkg;

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// major opcodes
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opRtype = 7'b0110011;
	localparam logic [6:0] opItype = 7'b0010011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opAuipc = 7'b0010111;

	// funct3 for branches
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [2:0] f3Blt = 3'b100;
	localparam logic [2:0] f3Bge = 3'b101;
	localparam logic [2:0] f3Bltu = 3'b110;
	localparam logic [2:0] f3Bgeu = 3'b111;

	// funct3 for the ALU groups, shared by register and immediate forms
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Sltu = 3'b011;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	// word-sized memory access and jalr
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3Jalr = 3'b000;

	// forwarding selects
	localparam logic [1:0] fwdNone = 2'b00;
	localparam logic [1:0] fwdWb = 2'b01;
	localparam logic [1:0] fwdMem = 2'b10;

	typedef logic [xlen-1:0] word_t;
	typedef logic [regAddrW-1:0] regIdx_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSll, aluSrl, aluSra,
		aluSlt, aluSltu, aluEq, aluNe, aluLt, aluGe, aluLtu, aluGeu
	} aluOp_e;

	typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSrc_e;

	typedef enum logic [1:0] {aReg, aZero, aPc} aSrc_e;

	typedef struct packed {
		logic regWrite;
		resultSrc_e resultSrc;
		logic memWrite;
		logic jump;
		logic branch;
		aSrc_e aSrc;
		logic bFromImm;
		logic targetFromReg;
		aluOp_e aluOp;
	} ctrl_t;

	typedef struct packed {
		word_t instr;
		word_t pc;
		word_t pcPlus4;
	} ifId_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t rs1Val;
		word_t rs2Val;
		word_t pc;
		word_t imm;
		word_t pcPlus4;
		regIdx_t rd;
		regIdx_t rs1;
		regIdx_t rs2;
	} idEx_t;

	typedef struct packed {
		logic regWrite;
		resultSrc_e resultSrc;
		logic memWrite;
		word_t aluResult;
		word_t storeData;
		word_t pcPlus4;
		regIdx_t rd;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		resultSrc_e resultSrc;
		word_t aluResult;
		word_t loadData;
		word_t pcPlus4;
		regIdx_t rd;
	} memWb_t;

	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic write;
	} dmemReq_t;

endpackage

`default_nettype wire

/* source/pipeStageReg.sv */
`timescale 1ns/1ps
`default_nettype none

module pipeStageReg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic flush,
	input payload_t d,
	output payload_t q
);

	// flush beats stall so a held slot can still become a bubble
	always_ff @(posedge clk) begin
		if (rst || flush)
			q <= '0;
		else if (!stall)
			q <= d;
	end

endmodule

`default_nettype wire

/* source/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
	import rvPkg::*;
(
	input word_t instr,
	output ctrl_t ctrl,
	output word_t imm
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic alt;
	word_t immI, immShift, immS, immB, immJ, immU;
	aluOp_e arithOp;
	aluOp_e branchOp;
	logic branchOk;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	// funct7 bit 5 picks sub and sra
	assign alt = instr[30];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immShift = {27'b0, instr[24:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign immU = {instr[31:12], 12'b0};

	// sub exists only in register form, sra in both
	always_comb begin
		case (funct3)
			f3AddSub: arithOp = (opcode == opRtype && alt) ? aluSub : aluAdd;
			f3Sll: arithOp = aluSll;
			f3Slt: arithOp = aluSlt;
			f3Sltu: arithOp = aluSltu;
			f3Xor: arithOp = aluXor;
			f3SrlSra: arithOp = alt ? aluSra : aluSrl;
			f3Or: arithOp = aluOr;
			f3And: arithOp = aluAnd;
			default: arithOp = aluAdd;
		endcase
	end

	always_comb begin
		branchOk = 1'b1;
		case (funct3)
			f3Beq: branchOp = aluEq;
			f3Bne: branchOp = aluNe;
			f3Blt: branchOp = aluLt;
			f3Bge: branchOp = aluGe;
			f3Bltu: branchOp = aluLtu;
			f3Bgeu: branchOp = aluGeu;
			default: begin
				branchOp = aluAdd;
				branchOk = 1'b0;
			end
		endcase
	end

	// anything not matched below stays a bubble
	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			opLoad: if (funct3 == f3Word) begin
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = resMem;
				ctrl.bFromImm = 1'b1;
				imm = immI;
			end
			opStore: if (funct3 == f3Word) begin
				ctrl.memWrite = 1'b1;
				ctrl.bFromImm = 1'b1;
				imm = immS;
			end
			opRtype: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluOp = arithOp;
			end
			opItype: begin
				ctrl.regWrite = 1'b1;
				ctrl.bFromImm = 1'b1;
				ctrl.aluOp = arithOp;
				imm = (funct3 == f3Sll || funct3 == f3SrlSra) ? immShift : immI;
			end
			opBranch: if (branchOk) begin
				ctrl.branch = 1'b1;
				ctrl.aluOp = branchOp;
				imm = immB;
			end
			opJal: begin
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = resPc4;
				ctrl.jump = 1'b1;
				imm = immJ;
			end
			opJalr: if (funct3 == f3Jalr) begin
				ctrl.regWrite = 1'b1;
				ctrl.resultSrc = resPc4;
				ctrl.jump = 1'b1;
				ctrl.targetFromReg = 1'b1;
				imm = immI;
			end
			opLui: begin
				ctrl.regWrite = 1'b1;
				ctrl.aSrc = aZero;
				ctrl.bFromImm = 1'b1;
				imm = immU;
			end
			opAuipc: begin
				ctrl.regWrite = 1'b1;
				ctrl.aSrc = aPc;
				ctrl.bFromImm = 1'b1;
				imm = immU;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile
	import rvPkg::*;
(
	input logic clk,
	input logic rst,
	input regIdx_t rs1,
	input regIdx_t rs2,
	input regIdx_t rd,
	input logic we,
	input word_t wdata,
	output word_t rdata1,
	output word_t rdata2
);

	word_t regs [1:31];

	// x0 reads zero, a same-cycle write bypasses the array
	function automatic word_t readPort(input regIdx_t idx);
		if (idx == '0)
			return '0;
		if (we && idx == rd)
			return wdata;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != '0) begin
			regs[rd] <= wdata;
		end
	end

	always_comb begin
		rdata1 = readPort(rs1);
		rdata2 = readPort(rs2);
	end

endmodule

`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit
	import rvPkg::*;
(
	input aluOp_e op,
	input word_t a,
	input word_t b,
	output word_t result,
	output logic branchTaken
);

	logic [4:0] shamt;
	logic lessS;
	logic lessU;
	logic equal;

	assign shamt = b[4:0];
	assign lessS = $signed(a) < $signed(b);
	assign lessU = a < b;
	assign equal = a == b;

	always_comb begin
		result = '0;
		branchTaken = 1'b0;
		case (op)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluSll: result = a << shamt;
			aluSrl: result = a >> shamt;
			aluSra: result = $signed(a) >>> shamt;
			aluSlt: result = word_t'(lessS);
			aluSltu: result = word_t'(lessU);
			// branch compares only drive the condition
			aluEq: branchTaken = equal;
			aluNe: branchTaken = !equal;
			aluLt: branchTaken = lessS;
			aluGe: branchTaken = !lessS;
			aluLtu: branchTaken = lessU;
			aluGeu: branchTaken = !lessU;
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

/* source/hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
	import rvPkg::*;
(
	input regIdx_t rs1D,
	input regIdx_t rs2D,
	input regIdx_t rs1E,
	input regIdx_t rs2E,
	input regIdx_t rdE,
	input logic loadE,
	input regIdx_t rdM,
	input logic regWriteM,
	input regIdx_t rdW,
	input logic regWriteW,
	input logic redirect,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic stall,
	output logic flushD,
	output logic flushE
);

	// the younger producer in memory wins over writeback
	function automatic logic [1:0] fwdSel(input regIdx_t rs, input regIdx_t rdMem,
		input logic weMem, input regIdx_t rdWb, input logic weWb);
		if (rs == '0)
			return fwdNone;
		if (weMem && rs == rdMem)
			return fwdMem;
		if (weWb && rs == rdWb)
			return fwdWb;
		return fwdNone;
	endfunction

	assign fwdA = fwdSel(rs1E, rdM, regWriteM, rdW, regWriteW);
	assign fwdB = fwdSel(rs2E, rdM, regWriteM, rdW, regWriteW);

	// load result is not ready until writeback, hold decode one cycle
	assign stall = loadE && rdE != '0 && (rs1D == rdE || rs2D == rdE);

	assign flushD = redirect;
	assign flushE = stall || redirect;

endmodule

`default_nettype wire

/* source/rvCore.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCore
	import rvPkg::*;
(
	input logic clk,
	input logic rst,
	input word_t bootAddr,
	output word_t imemAddr,
	input word_t imemData,
	output dmemReq_t dmemReq,
	input word_t dmemRdata
);

	word_t pc, pcPlus4, pcNext;
	ifId_t ifIdNext, ifId;
	idEx_t idExNext, idEx;
	exMem_t exMemNext, exMem;
	memWb_t memWbNext, memWb;

	ctrl_t ctrlD;
	word_t immD, rs1ValD, rs2ValD;
	regIdx_t rs1D, rs2D, rdD;

	logic [1:0] fwdA, fwdB;
	logic stall, flushD, flushE;
	word_t fwdValM, rs1ValE, rs2ValE, srcA, srcB, aluResult, targetBase, target;
	logic branchTaken, redirect;
	word_t resultW;

	// fetch
	assign pcPlus4 = pc + word_t'(4);
	assign pcNext = redirect ? target : pcPlus4;
	assign imemAddr = pc;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= bootAddr;
		else if (!stall)
			pc <= pcNext;
	end

	assign ifIdNext = '{instr: imemData, pc: pc, pcPlus4: pcPlus4};

	pipeStageReg #(.payload_t(ifId_t)) u_ifIdReg (
		.clk(clk), .rst(rst), .stall(stall), .flush(flushD), .d(ifIdNext), .q(ifId)
	);

	// decode
	assign rs1D = ifId.instr[19:15];
	assign rs2D = ifId.instr[24:20];
	assign rdD = ifId.instr[11:7];

	instrDecoder u_instrDecoder (.instr(ifId.instr), .ctrl(ctrlD), .imm(immD));

	regFile u_regFile (
		.clk(clk), .rst(rst), .rs1(rs1D), .rs2(rs2D), .rd(memWb.rd),
		.we(memWb.regWrite), .wdata(resultW), .rdata1(rs1ValD), .rdata2(rs2ValD)
	);

	assign idExNext = '{ctrl: ctrlD, rs1Val: rs1ValD, rs2Val: rs2ValD, pc: ifId.pc,
		imm: immD, pcPlus4: ifId.pcPlus4, rd: rdD, rs1: rs1D, rs2: rs2D};

	pipeStageReg #(.payload_t(idEx_t)) u_idExReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(flushE), .d(idExNext), .q(idEx)
	);

	// execute
	// jal/jalr in memory forward their link value
	assign fwdValM = (exMem.resultSrc == resPc4) ? exMem.pcPlus4 : exMem.aluResult;

	assign rs1ValE = (fwdA == fwdMem) ? fwdValM : (fwdA == fwdWb) ? resultW : idEx.rs1Val;
	assign rs2ValE = (fwdB == fwdMem) ? fwdValM : (fwdB == fwdWb) ? resultW : idEx.rs2Val;

	always_comb begin
		case (idEx.ctrl.aSrc)
			aZero: srcA = '0;
			aPc: srcA = idEx.pc;
			default: srcA = rs1ValE;
		endcase
	end

	assign srcB = idEx.ctrl.bFromImm ? idEx.imm : rs2ValE;

	aluUnit u_aluUnit (
		.op(idEx.ctrl.aluOp), .a(srcA), .b(srcB), .result(aluResult),
		.branchTaken(branchTaken)
	);

	// jalr clears bit 0 of its target
	assign targetBase = idEx.ctrl.targetFromReg ? rs1ValE : idEx.pc;
	assign target = (targetBase + idEx.imm) & ~word_t'(1);
	assign redirect = (branchTaken && idEx.ctrl.branch) || idEx.ctrl.jump;

	hazardUnit u_hazardUnit (
		.rs1D(rs1D), .rs2D(rs2D), .rs1E(idEx.rs1), .rs2E(idEx.rs2), .rdE(idEx.rd),
		.loadE(idEx.ctrl.resultSrc == resMem), .rdM(exMem.rd), .regWriteM(exMem.regWrite),
		.rdW(memWb.rd), .regWriteW(memWb.regWrite), .redirect(redirect),
		.fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flushD(flushD), .flushE(flushE)
	);

	assign exMemNext = '{regWrite: idEx.ctrl.regWrite, resultSrc: idEx.ctrl.resultSrc,
		memWrite: idEx.ctrl.memWrite, aluResult: aluResult, storeData: rs2ValE,
		pcPlus4: idEx.pcPlus4, rd: idEx.rd};

	pipeStageReg #(.payload_t(exMem_t)) u_exMemReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(exMemNext), .q(exMem)
	);

	// memory
	assign dmemReq = '{addr: exMem.aluResult, wdata: exMem.storeData, write: exMem.memWrite};

	assign memWbNext = '{regWrite: exMem.regWrite, resultSrc: exMem.resultSrc,
		aluResult: exMem.aluResult, loadData: dmemRdata, pcPlus4: exMem.pcPlus4,
		rd: exMem.rd};

	pipeStageReg #(.payload_t(memWb_t)) u_memWbReg (
		.clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(memWbNext), .q(memWb)
	);

	// writeback
	always_comb begin
		case (memWb.resultSrc)
			resMem: resultW = memWb.loadData;
			resPc4: resultW = memWb.pcPlus4;
			default: resultW = memWb.aluResult;
		endcase
	end

endmodule

`default_nettype wire

/* tests/rvCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rvCoreTb
	import rvPkg::*;
;

	localparam int progLen = 60;
	localparam int nStores = 22;
	localparam int resetCycles = 8;
	localparam int clkPeriod = 10;
	// five cycles per program entry is far more than the program needs
	localparam int watchdogNs = (resetCycles + progLen * 5) * clkPeriod;

	logic clk;
	logic rst;
	word_t bootAddr;
	word_t imemAddr;
	word_t imemData;
	dmemReq_t dmemReq;
	word_t dmemRdata;

	word_t imem [64];
	word_t dmem [256];
	word_t prog [progLen];
	dmemReq_t expStores [nStores];
	int storeCount;

	rvCore u_rvCore (
		.clk(clk), .rst(rst), .bootAddr(bootAddr), .imemAddr(imemAddr),
		.imemData(imemData), .dmemReq(dmemReq), .dmemRdata(dmemRdata)
	);

	// instruction encoders following the RV32I base formats
	function automatic word_t rType(input logic [6:0] f7, input logic [2:0] f3, input int rd,
		input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opRtype};
	endfunction

	function automatic word_t iType(input logic [6:0] op, input logic [2:0] f3, input int rd,
		input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
	endfunction

	function automatic word_t storeWord(input int rs2, input int off, input int rs1);
		return {off[11:5], rs2[4:0], rs1[4:0], f3Word, off[4:0], opStore};
	endfunction

	function automatic word_t bType(input logic [2:0] f3, input int rs1, input int rs2,
		input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
	endfunction

	function automatic word_t uType(input logic [6:0] op, input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], op};
	endfunction

	function automatic word_t jType(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
	endfunction

	task automatic checkReq(input dmemReq_t got, input dmemReq_t exp);
		if (got.write !== exp.write) begin
			$display("mismatch dmemReq.write: got %h, expected %h", got.write, exp.write);
			$display("** FAIL **");
			$fatal(1, "stopping at first error");
		end
		if (got.addr !== exp.addr) begin
			$display("mismatch dmemReq.addr: got %h, expected %h", got.addr, exp.addr);
			$display("** FAIL **");
			$fatal(1, "stopping at first error");
		end
	endtask

	task automatic checkWord(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("mismatch %s: got %h, expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1, "stopping at first error");
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// both memories answer in the same cycle
	assign imemData = imem[imemAddr[7:2]];
	assign dmemRdata = dmem[dmemReq.addr[9:2]];

	always @(posedge clk) begin
		if (!rst && dmemReq.write)
			dmem[dmemReq.addr[9:2]] <= dmemReq.wdata;
	end

	// every store must match the next table row, in order
	always @(posedge clk) begin
		if (!rst && dmemReq.write) begin
			if (storeCount >= nStores) begin
				$display("unexpected extra store of %h to address %h",
					dmemReq.wdata, dmemReq.addr);
				$display("** FAIL **");
				$fatal(1, "stopping at first error");
			end else begin
				checkReq(dmemReq, expStores[storeCount]);
				checkWord("dmemReq.wdata", dmemReq.wdata, expStores[storeCount].wdata);
				storeCount = storeCount + 1;
			end
		end
	end

	initial begin
		#(watchdogNs);
		$display("timeout: program did not finish, %0d of %0d stores seen",
			storeCount, nStores);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst = 1'b1;
		bootAddr = '0;
		storeCount = 0;
		prog = '{
			// alu ops with forwarding from memory and writeback
			iType(opItype, f3AddSub, 1, 0, 25),
			iType(opItype, f3AddSub, 2, 0, -7),
			rType(7'h00, f3AddSub, 3, 1, 2),
			rType(7'h20, f3AddSub, 4, 2, 1),
			storeWord(3, 'h100, 0),
			storeWord(4, 'h104, 0),
			iType(opItype, f3AddSub, 6, 0, 3),
			rType(7'h20, f3SrlSra, 5, 4, 6),
			rType(7'h00, f3Sll, 7, 1, 6),
			rType(7'h00, f3Slt, 8, 2, 1),
			rType(7'h00, f3Sltu, 9, 2, 1),
			iType(opItype, f3SrlSra, 10, 2, 28),
			iType(opItype, f3Xor, 11, 1, 'h0f0),
			storeWord(5, 'h108, 0),
			storeWord(7, 'h10c, 0),
			storeWord(8, 'h110, 0),
			storeWord(9, 'h114, 0),
			storeWord(10, 'h118, 0),
			storeWord(11, 'h11c, 0),
			// load-use pairs
			iType(opLoad, f3Word, 12, 0, 'h104),
			iType(opItype, f3AddSub, 13, 12, 'h40),
			storeWord(13, 'h120, 0),
			iType(opLoad, f3Word, 14, 0, 'h100),
			storeWord(14, 'h124, 0),
			// taken branches skip two bad stores
			bType(f3Beq, 1, 1, 12),
			storeWord(2, 'h1f0, 0),
			storeWord(2, 'h1f0, 0),
			bType(f3Bne, 1, 1, 12),
			storeWord(1, 'h128, 0),
			storeWord(2, 'h12c, 0),
			bType(f3Blt, 2, 1, 12),
			storeWord(2, 'h1f0, 0),
			storeWord(2, 'h1f0, 0),
			bType(f3Bge, 2, 1, 12),
			storeWord(3, 'h130, 0),
			storeWord(4, 'h134, 0),
			bType(f3Bltu, 1, 2, 12),
			storeWord(2, 'h1f0, 0),
			storeWord(2, 'h1f0, 0),
			bType(f3Bgeu, 1, 2, 12),
			storeWord(5, 'h138, 0),
			storeWord(7, 'h13c, 0),
			// jumps and upper immediates
			jType(16, 12),
			storeWord(2, 'h1f0, 0),
			storeWord(2, 'h1f0, 0),
			storeWord(16, 'h140, 0),
			uType(opAuipc, 17, 'h12345),
			uType(opLui, 19, 'habcde),
			storeWord(17, 'h144, 0),
			storeWord(19, 'h148, 0),
			uType(opAuipc, 20, 0),
			iType(opJalr, f3Jalr, 21, 20, 16),
			storeWord(2, 'h1f0, 0),
			storeWord(2, 'h1f0, 0),
			storeWord(21, 'h14c, 0),
			// x0 ignores writes
			iType(opItype, f3AddSub, 0, 0, 123),
			rType(7'h00, f3AddSub, 22, 0, 0),
			storeWord(0, 'h150, 0),
			storeWord(22, 'h154, 0),
			jType(0, 0)
		};
		expStores = '{
			'{32'h00000100, 32'h00000012, 1'b1},
			'{32'h00000104, 32'hffffffe0, 1'b1},
			'{32'h00000108, 32'hfffffffc, 1'b1},
			'{32'h0000010c, 32'h000000c8, 1'b1},
			'{32'h00000110, 32'h00000001, 1'b1},
			'{32'h00000114, 32'h00000000, 1'b1},
			'{32'h00000118, 32'h0000000f, 1'b1},
			'{32'h0000011c, 32'h000000e9, 1'b1},
			'{32'h00000120, 32'h00000020, 1'b1},
			'{32'h00000124, 32'h00000012, 1'b1},
			'{32'h00000128, 32'h00000019, 1'b1},
			'{32'h0000012c, 32'hfffffff9, 1'b1},
			'{32'h00000130, 32'h00000012, 1'b1},
			'{32'h00000134, 32'hffffffe0, 1'b1},
			'{32'h00000138, 32'hfffffffc, 1'b1},
			'{32'h0000013c, 32'h000000c8, 1'b1},
			'{32'h00000140, 32'h000000ac, 1'b1},
			'{32'h00000144, 32'h123450b8, 1'b1},
			'{32'h00000148, 32'habcde000, 1'b1},
			'{32'h0000014c, 32'h000000d0, 1'b1},
			'{32'h00000150, 32'h00000000, 1'b1},
			'{32'h00000154, 32'h00000000, 1'b1}
		};
		// unused instruction slots decode as bubbles
		for (int i = 0; i < 64; i++)
			imem[i] = (i < progLen) ? prog[i] : '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = 32'hd0d00000 + i * 4;
		for (int i = 0; i < resetCycles; i++) begin
			@(negedge clk);
			// pc sits at the boot address with no store in flight
			checkWord("imemAddr", imemAddr, bootAddr);
			checkReq(dmemReq, '0);
		end
		rst = 1'b0;
		wait (storeCount == nStores);
		// give a duplicate or stray store time to show up
		repeat (10) @(posedge clk);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
source/rvPkg.sv
source/pipeStageReg.sv
source/instrDecoder.sv
source/regFile.sv
source/aluUnit.sv
source/hazardUnit.sv
source/rvCore.sv
tests/rvCoreTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f verilog.f --top-module rvCoreTb -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
